// File: logic/line_strobe_if.sv
`timescale 1ns/10ps

// per-line timing from the horizontal to the vertical generator
interface line_strobe_if;

	logic hsync_start; // one clock, hsync rising point
	logic line_start;  // one clock, hsync falling point
	logic hint_start;  // one clock, start of line for the INT decode
	logic hblank;      // level, horizontal blanking

	// horizontal generator side
	modport src
	(
		output hsync_start,
		output line_start,
		output hint_start,
		output hblank
	);

	// vertical generator side, no handshake back
	modport sink
	(
		input hsync_start,
		input line_start,
		input hint_start,
		input hblank
	);

endinterface

// File: logic/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// horizontal geometry, in pixel clocks from hcount 0
`define VID_HPERIOD      9'd448 // clocks per line
`define VID_HSYNC_BEG    9'd16  // hsync rises here, also the hsync_start point
`define VID_HSYNC_END    9'd48  // hsync falls here, also the line_start point
`define VID_HBLNK_END    9'd88  // hblank covers 0..87
`define VID_HPIX_BEG     9'd136
`define VID_HPIX_END     9'd392 // 256 picture clocks
`define VID_HINT_BEG     9'd0   // hint_start point

// vertical geometry, in lines
`define VID_VPERIOD      9'd320 // pentagon frame
`define VID_VBLNK_BEG    9'd0
`define VID_VBLNK_END    9'd32
`define VID_VSYNC_BEG    9'd8
`define VID_VSYNC_END    9'd11
`define VID_INT_LINE     9'd0

// picture window per raster height, border split evenly around it
`define VID_VPIX_BEG_192 9'd80
`define VID_VPIX_END_192 9'd272
`define VID_VPIX_BEG_200 9'd76
`define VID_VPIX_END_200 9'd276
`define VID_VPIX_BEG_240 9'd56
`define VID_VPIX_END_240 9'd296
`define VID_VPIX_BEG_288 9'd32
`define VID_VPIX_END_288 9'd320 // equals the period, wraps to line 0

`define VID_TFETCH_LEAD  9'd16 // tile prefetch opens this many lines early
`define VID_TFETCH_TRAIL 9'd8  // and closes this many lines before vpix ends

`define VID_INT_LEN      32    // z80 INT width in clocks

`endif

// File: logic/video_int_gen.sv
`timescale 1ns/10ps

`include "video_cfg.svh"

module video_int_gen import video_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic int_start, // one clock per frame
	output logic int_n      // z80 INT, active low
);

	localparam int CNT_W = $clog2(`VID_INT_LEN);

	int_state_t       state;
	logic [CNT_W-1:0] remain; // clocks left after the current one

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= INT_IDLE;
			remain <= '0;
		end
		else if (int_start) // also restarts a running INT
		begin
			state  <= INT_ACTIVE;
			remain <= CNT_W'(`VID_INT_LEN - 1);
		end
		else if (state == INT_ACTIVE)
		begin
			if (remain == '0)
				state <= INT_IDLE;
			else
				remain <= remain - 1'b1;
		end
	end

	assign int_n = (state != INT_ACTIVE);

endmodule

// File: logic/video_pkg.sv
package video_pkg;

	// pixel position within a line, 0..447
	typedef logic [8:0] hcount_t;

	// line number within a frame, 0..319
	typedef logic [8:0] vcount_t;

	// raster height code
	// 00=192 01=200 10=240 11=288
	typedef logic [1:0] rres_t;

	// interrupt stretcher
	typedef enum logic
	{
		INT_IDLE,   // int_n released
		INT_ACTIVE  // int_n held low, counter running
	} int_state_t;

endpackage

// File: logic/video_sync_h.sv
`timescale 1ns/10ps

`include "video_cfg.svh"

module video_sync_h import video_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	line_strobe_if.src    strobes,
	output hcount_t       hcount,
	output logic          hsync,
	output logic          hpix
);

	logic at_line_end; // last clock of the line

	assign at_line_end = (hcount == (`VID_HPERIOD - 9'd1));

	// free-running pixel counter
	always_ff @(posedge clk)
	begin
		if (reset)
			hcount <= '0;
		else if (at_line_end)
			hcount <= '0;
		else
			hcount <= hcount + 9'd1;
	end

	// levels, one clock behind the hcount that sets or clears them
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync          <= 1'b0;
			strobes.hblank <= 1'b0;
			hpix           <= 1'b0;
		end
		else
		begin
			if (hcount == `VID_HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == `VID_HSYNC_END)
				hsync <= 1'b0;

			if (hcount == 9'd0) // blank starts with the line
				strobes.hblank <= 1'b1;
			else if (hcount == `VID_HBLNK_END)
				strobes.hblank <= 1'b0;

			if (hcount == `VID_HPIX_BEG)
				hpix <= 1'b1;
			else if (hcount == `VID_HPIX_END)
				hpix <= 1'b0;
		end
	end

	// one-clock strobes, each fires once per line
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			strobes.hsync_start <= 1'b0;
			strobes.line_start  <= 1'b0;
			strobes.hint_start  <= 1'b0;
		end
		else
		begin
			strobes.hsync_start <= (hcount == `VID_HSYNC_BEG);
			strobes.line_start  <= (hcount == `VID_HSYNC_END); // end of hsync ends vsync too
			strobes.hint_start  <= (hcount == `VID_HINT_BEG);
		end
	end

endmodule

// File: logic/video_sync_v.sv
`timescale 1ns/10ps

`include "video_cfg.svh"

module video_sync_v import video_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	line_strobe_if.sink   strobes,
	input  rres_t         rres,      // sampled every line, quasi-static
	output vcount_t       vcount,
	output logic          vblank,
	output logic          vsync,
	output logic          vpix,      // line carries pixels, not just border
	output logic          vtfetch,   // tile and x-scroll prefetch window
	output logic          yctr_init, // line 0 of the y counter
	output logic          int_start  // one-shot, starts the z80 INT
);

	vcount_t vp_beg;      // first picture line
	vcount_t vp_end;      // line after the last picture line
	vcount_t vp_end_cmp;  // vp_end folded into the counter range
	vcount_t tf_beg;
	vcount_t tf_end;
	logic    line_step;   // vertical levels move only here

	// window boundaries for the selected raster height
	always_comb
	begin
		case (rres)
			2'b00:
			begin
				vp_beg = `VID_VPIX_BEG_192;
				vp_end = `VID_VPIX_END_192;
			end
			2'b01:
			begin
				vp_beg = `VID_VPIX_BEG_200;
				vp_end = `VID_VPIX_END_200;
			end
			2'b10:
			begin
				vp_beg = `VID_VPIX_BEG_240;
				vp_end = `VID_VPIX_END_240;
			end
			default:
			begin
				vp_beg = `VID_VPIX_BEG_288;
				vp_end = `VID_VPIX_END_288;
			end
		endcase
		// 288 lines run to the frame end, so vpix clears on line 0
		vp_end_cmp = (vp_end == `VID_VPERIOD) ? '0 : vp_end;
	end

	assign tf_beg = vp_beg - `VID_TFETCH_LEAD;
	assign tf_end = vp_end - `VID_TFETCH_TRAIL;

	// hsync_start always lands inside hblank
	assign line_step = strobes.hsync_start & strobes.hblank;

	assign yctr_init = (vcount == tf_beg); // whole line, one per frame

	// line counter
	always_ff @(posedge clk)
	begin
		if (reset)
			vcount <= '0;
		else if (line_step)
		begin
			if (vcount == (`VID_VPERIOD - 9'd1))
				vcount <= '0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// blank, picture and prefetch levels, all on line boundaries
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vblank  <= 1'b0;
			vpix    <= 1'b0;
			vtfetch <= 1'b0;
		end
		else if (line_step)
		begin
			if (vcount == `VID_VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == `VID_VBLNK_END)
				vblank <= 1'b0;

			if (vcount == vp_beg)
				vpix <= 1'b1;
			else if (vcount == vp_end_cmp)
				vpix <= 1'b0;

			if (vcount == tf_beg)
				vtfetch <= 1'b1;
			else if (vcount == tf_end)
				vtfetch <= 1'b0;
		end
	end

	// vsync keeps every hsync edge, it ends at the line_start that follows
	// the hsync_start of the last sync line
	always_ff @(posedge clk)
	begin
		if (reset)
			vsync <= 1'b0;
		else if (line_step && (vcount == `VID_VSYNC_BEG))
			vsync <= 1'b1;
		else if (strobes.line_start && (vcount == (`VID_VSYNC_END + 9'd1)))
			vsync <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			int_start <= 1'b0;
		else
			int_start <= strobes.hint_start && (vcount == `VID_INT_LINE); // one clock
	end

endmodule

// File: logic/video_timing_top.sv
`timescale 1ns/10ps

module video_timing_top import video_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  rres_t   rres,      // raster height code
	output hcount_t hcount,
	output vcount_t vcount,
	output logic    hsync,
	output logic    hblank,
	output logic    hpix,
	output logic    vsync,
	output logic    vblank,
	output logic    vpix,
	output logic    vtfetch,
	output logic    yctr_init,
	output logic    int_n
);

	logic int_start; // vertical to INT stretcher

	line_strobe_if strobes ();

	video_sync_h u_sync_h
	(
		.clk     (clk),
		.reset   (reset),
		.strobes (strobes.src),
		.hcount  (hcount),
		.hsync   (hsync),
		.hpix    (hpix)
	);

	video_sync_v u_sync_v
	(
		.clk       (clk),
		.reset     (reset),
		.strobes   (strobes.sink),
		.rres      (rres),
		.vcount    (vcount),
		.vblank    (vblank),
		.vsync     (vsync),
		.vpix      (vpix),
		.vtfetch   (vtfetch),
		.yctr_init (yctr_init),
		.int_start (int_start)
	);

	video_int_gen u_int_gen
	(
		.clk       (clk),
		.reset     (reset),
		.int_start (int_start),
		.int_n     (int_n)
	);

	assign hblank = strobes.hblank; // blank level lives in the strobe bundle

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the video timing testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module video_timing_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vvideo_timing_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sources.f
+incdir+logic
logic/video_pkg.sv
logic/line_strobe_if.sv
logic/video_sync_h.sv
logic/video_sync_v.sv
logic/video_int_gen.sv
logic/video_timing_top.sv
tb/video_timing_tb.sv

// File: tb/video_testdata.txt
# rres  vpix_lines  vblank_to_vpix  vtfetch_lines  yctr_init_end_to_vpix
# counts and offsets in lines, sampled at each hsync rise of one frame
0 192 80 200 16
1 200 76 208 16
2 240 56 248 16
3 288 32 296 16

// File: tb/video_timing_tb.sv
`timescale 1ns/10ps

module video_timing_tb import video_pkg::*;
();

	localparam int CLK_NS      = 8;
	localparam int LINE_CLKS   = 448; // pixel clocks per line
	localparam int FRAME_LINES = 320;
	localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;

	logic    clk;
	logic    reset;
	rres_t   rres;
	hcount_t hcount;
	vcount_t vcount;
	logic    hsync, hblank, hpix;
	logic    vsync, vblank, vpix, vtfetch, yctr_init, int_n;

	int n_cases = 0; // watchdog starts once this is known
	int q_code[$], q_vpix[$], q_voff[$], q_tf[$], q_yoff[$];

	video_timing_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic fail_run();
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input longint expected,
		input longint actual);
		assert (actual == expected)
		else
		begin
			$display("error at %0d ns: %s expected %0d got %0d",
				$time, name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("at %0d ns: %s", $time, what);
			fail_run();
		end
	endtask

	// {int_n,hsync,vsync,vblank,vpix,vtfetch} must read 6'b100000
	task automatic check_reset_outputs();
		check_value("{int_n,hsync,vsync,vblank,vpix,vtfetch}", 6'b100000,
			{int_n, hsync, vsync, vblank, vpix, vtfetch});
		check_value("vcount", 0, vcount);
	endtask

	// reset with a new raster height, skip a frame, measure the next one
	task automatic run_case(input int code, input int e_vpix, input int e_voff,
		input int e_tf, input int e_yoff);
		longint t_vb1;
		int c_hs = 0, c_vb = -1, line = 0, int_low = 0;
		int vs_clks = 0, hb_clks = 0, hp_clks = 0;
		int n_vb = 0, n_vbr = 0, n_vp = 0, n_tf = 0, n_yc = 0, n_int = 0;
		int r_vb = -1, r_vp = -1, f_vp = -1, r_tf = -1, f_tf = -1, f_yc = -1;
		logic p_hs, p_vb, p_vs, p_int;    // previous clock
		logic q_vb, q_vp, q_tf, q_yc;     // previous line sample
		@(negedge clk);
		reset = 1'b1;
		rres = rres_t'(code);
		repeat (8)
		begin
			@(negedge clk);
			check_reset_outputs();
		end
		reset = 1'b0;
		@(negedge clk);
		check_reset_outputs();  // first clock out of reset
		while (!vblank)
			@(negedge clk);
		t_vb1 = $time;          // frame 1 begins
		while (!int_n)
			@(negedge clk);
		while (int_n)
			@(negedge clk);     // INT of frame 2 opens the window
		p_hs = hsync;
		p_vb = vblank;
		p_vs = vsync;
		p_int = 1'b1;           // count the opening fall
		for (int c = 0; c < FRAME_CLKS; c++)
		begin
			if (hsync && !p_hs)
			begin
				check_value("hcount at hsync rise", 17, hcount); // one clock after hcount 16
				if (line > 0)
				begin
					check_value("hsync period", LINE_CLKS, c - c_hs);
					check_value("hblank clocks per line", 88, hb_clks);
					check_value("hpix clocks per line", 256, hp_clks);
				end
				else
				begin
					q_vb = vblank;  // no edges on the first sample
					q_vp = vpix;
					q_tf = vtfetch;
					q_yc = yctr_init;
				end
				c_hs = c;
				hb_clks = 0;
				hp_clks = 0;
				n_vb += vblank;
				n_vp += vpix;
				n_tf += vtfetch;
				n_yc += yctr_init;
				if (vblank && !q_vb) r_vb = line;
				if (vpix && !q_vp) r_vp = line;
				if (!vpix && q_vp) f_vp = line;
				if (vtfetch && !q_tf) r_tf = line;
				if (!vtfetch && q_tf) f_tf = line;
				if (!yctr_init && q_yc) f_yc = line;
				q_vb = vblank;
				q_vp = vpix;
				q_tf = vtfetch;
				q_yc = yctr_init;
				line++;
			end
			if (vblank && !p_vb)
			begin
				n_vbr++;
				c_vb = c;
				check_cond(c < LINE_CLKS, "vblank did not rise within one line of the INT");
				check_value("vblank period in clocks", FRAME_CLKS, ($time - t_vb1) / CLK_NS);
			end
			if (vsync && !p_vs)
				check_value("vsync rise after vblank in clocks", 8 * LINE_CLKS, c - c_vb);
			if (!int_n && p_int)
				n_int++;
			int_low += !int_n;
			vs_clks += vsync;
			hb_clks += hblank;
			hp_clks += hpix;
			p_hs = hsync;
			p_vb = vblank;
			p_vs = vsync;
			p_int = int_n;
			@(negedge clk);
		end
		check_value("lines per frame", FRAME_LINES, line);
		check_value("vblank rises per frame", 1, n_vbr);
		check_value("vblank lines", 32, n_vb);
		check_cond(vs_clks > 3 * LINE_CLKS && vs_clks < 4 * LINE_CLKS,
			"vsync pulse is not between 3 and 4 lines long");
		check_value("vpix lines", e_vpix, n_vp);
		check_value("vpix offset from vblank", e_voff, r_vp - r_vb);
		check_value("vtfetch lines", e_tf, n_tf);
		check_value("vtfetch lead before vpix", 16, r_vp - r_tf);
		check_value("vtfetch trail before vpix end", 8,
			(f_vp - f_tf + FRAME_LINES) % FRAME_LINES);
		check_value("yctr_init lines", 1, n_yc);
		check_value("yctr_init end to vpix", e_yoff, r_vp - f_yc);
		check_value("int_n falls per frame", 1, n_int);
		check_value("int_n low clocks", 32, int_low);
		check_cond(!int_n && p_int, "int_n did not fall again one frame later");
	endtask

	initial
	begin
		int fd;
		int a_code, a_vpix, a_voff, a_tf, a_yoff;
		string text;
		reset = 1'b1;
		rres = '0;
		fd = $fopen("tb/video_testdata.txt", "r");
		check_cond(fd != 0, "cannot open tb/video_testdata.txt");
		while (!$feof(fd))
		begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() > 0 && text[0] != "#" &&
				$sscanf(text, "%d %d %d %d %d", a_code, a_vpix, a_voff, a_tf, a_yoff) == 5)
			begin
				q_code.push_back(a_code);
				q_vpix.push_back(a_vpix);
				q_voff.push_back(a_voff);
				q_tf.push_back(a_tf);
				q_yoff.push_back(a_yoff);
			end
		end
		$fclose(fd);
		check_cond(q_code.size() > 0, "no test cases in tb/video_testdata.txt");
		n_cases = q_code.size();
		foreach (q_code[i])
			run_case(q_code[i], q_vpix[i], q_voff[i], q_tf[i], q_yoff[i]);
		$display("Test passed");
		$finish;
	end

	// two frames per case plus one spare case, and a margin for the resets
	initial
	begin
		longint limit_ns;
		wait (n_cases > 0);
		limit_ns = longint'(n_cases + 1) * 2 * FRAME_CLKS * CLK_NS + 100_000;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		fail_run();
	end

endmodule
